// ==== execPkg.sv ====
package execPkg;

	// ============================================================
	// Datapath words
	// ============================================================

	// Register and result word of both lanes
	typedef logic [63:0] Value;

	// Register number, wide enough for 64 entries
	typedef logic [5:0] RegAddr;

	// Instruction address that comes with each issued instruction
	typedef logic [63:0] CodeAddress;

	// Eight integer operations of an execute lane
	typedef enum logic [2:0] {
		aluAdd = 3'd0,
		aluSub = 3'd1,
		aluAnd = 3'd2,
		aluOr  = 3'd3,
		aluXor = 3'd4,
		aluSll = 3'd5,
		aluSrl = 3'd6,
		aluSlt = 3'd7
	} AluOp;

	// Source A of this register returns the lane's instruction address
	localparam RegAddr ipRegNum = 6'd31;

	// ============================================================
	// Control block register map (byte offsets)
	// ============================================================

	// Bit 0 is halt
	localparam logic [3:0] CTRL_OFFSET    = 4'h0;
	// Count of accepted instructions, read only
	localparam logic [3:0] RETIRED_OFFSET = 4'h4;
	// Register number shown in the debug window
	localparam logic [3:0] DBGADDR_OFFSET = 4'h8;
	// Low 32 bits of the selected register, read only
	localparam logic [3:0] DBGDATA_OFFSET = 4'hC;

endpackage

// ==== issueIf.sv ====
`timescale 1ns/10ps

// One issue slot of a lane
// The instruction is taken in a cycle where valid and ready are both high
interface issueIf import execPkg::*; ();

	logic valid;
	logic ready;
	AluOp op;
	RegAddr ra;
	RegAddr rb;
	RegAddr rd;
	logic useImm;
	Value imm;
	CodeAddress ip;

	// The top level fills the slot from its ports and the control block's ready
	modport top (output valid, ready, op, ra, rb, rd, useImm, imm, ip);

	// The lane only consumes the slot
	modport lane (input valid, ready, op, ra, rb, rd, useImm, imm, ip);

endinterface

// ==== gpRegfile.sv ====
`timescale 1ns/10ps

// Two write banks with a way bit per register pointing at the newest copy
module gpRegfile import execPkg::*; #(
	parameter int numRegs = 64
) (
	input logic clk,
	input logic rst,
	input logic wr0,
	input logic wr1,
	input RegAddr wa0,
	input RegAddr wa1,
	input Value wd0,
	input Value wd1,
	input CodeAddress ip0,
	input CodeAddress ip1,
	input RegAddr ra0,
	input RegAddr ra1,
	input RegAddr ra2,
	input RegAddr ra3,
	output Value o0,
	output Value o1,
	output Value o2,
	output Value o3,
	input RegAddr dbgRa,
	output Value dbgVal
);

	// Bank A belongs to write port 0, bank B to write port 1
	Value bankA [numRegs];
	Value bankB [numRegs];
	// Set means bank B holds the newest value
	logic [numRegs-1:0] way;

	// Both ports hit the same register, so port 0 is dropped
	logic sameAddr;

	assign sameAddr = wr0 && wr1 && (wa0 == wa1);

	// Addresses past the end of a smaller file are never stored
	function automatic logic inRange(RegAddr a);
		return int'(a) < numRegs;
	endfunction

	// Stored value, chosen by the way bit
	function automatic Value bankRead(RegAddr a);
		Value v;
		v = '0;
		if (inRange(a))
			v = way[a] ? bankB[a] : bankA[a];
		return v;
	endfunction

	// Same-cycle writes bypass the banks, port 1 first since it wins on a tie
	function automatic Value bypassRead(RegAddr a);
		Value v;
		if (wr1 && a == wa1)
			v = wd1;
		else if (wr0 && a == wa0)
			v = wd0;
		else
			v = bankRead(a);
		return v;
	endfunction

	// Lane read, with register 0 and optionally the address substitution on top
	function automatic Value laneRead(RegAddr a, logic ipSel, CodeAddress ip);
		Value v;
		if (a == '0)
			v = '0;
		else if (ipSel && a == ipRegNum)
			v = ip;
		else
			v = bypassRead(a);
		return v;
	endfunction

	always_ff @(posedge clk) begin
		if (rst) begin
			way <= '0;
			for (int i = 0; i < numRegs; i++) begin
				bankA[i] <= '0;
				bankB[i] <= '0;
			end
		end else begin
			if (wr0 && !sameAddr && inRange(wa0)) begin
				bankA[wa0] <= wd0;
				way[wa0] <= 1'b0;
			end
			if (wr1 && inRange(wa1)) begin
				bankB[wa1] <= wd1;
				way[wa1] <= 1'b1;
			end
		end
	end

	// Ports 0 and 2 are the A sources of lanes 0 and 1
	always_comb begin
		o0 = laneRead(ra0, 1'b1, ip0);
		o1 = laneRead(ra1, 1'b0, ip0);
		o2 = laneRead(ra2, 1'b1, ip1);
		o3 = laneRead(ra3, 1'b0, ip1);
		// The debug window sees the raw contents, register 0 included
		dbgVal = bypassRead(dbgRa);
	end

endmodule

// ==== aluLane.sv ====
`timescale 1ns/10ps

// One integer execute lane: operands come from the register file in the
// issue cycle and the result is written back in the next one
module aluLane import execPkg::*; (
	input logic clk,
	input logic rst,
	issueIf.lane iss,
	output RegAddr raA,
	output RegAddr raB,
	input Value valA,
	input Value valB,
	output logic wbValid,
	output RegAddr wbRd,
	output Value wbData
);

	logic accept;
	Value opB;
	Value result;

	assign accept = iss.valid && iss.ready;

	// Source registers go straight to the read ports
	assign raA = iss.ra;
	assign raB = iss.rb;

	// The immediate replaces source B
	assign opB = iss.useImm ? iss.imm : valB;

	// ============================================================
	// ALU
	// ============================================================

	always_comb begin
		result = '0;
		case (iss.op)
			aluAdd: result = valA + opB;
			aluSub: result = valA - opB;
			aluAnd: result = valA & opB;
			aluOr: result = valA | opB;
			aluXor: result = valA ^ opB;
			// Shifts use the low six bits of operand B
			aluSll: result = valA << opB[5:0];
			aluSrl: result = valA >> opB[5:0];
			aluSlt: result = Value'($signed(valA) < $signed(opB));
			default: result = '0;
		endcase
	end

	// ============================================================
	// Writeback stage
	// ============================================================

	// The lane never stalls here, each accepted instruction writes back next cycle
	always_ff @(posedge clk) begin
		if (rst)
			wbValid <= 1'b0;
		else
			wbValid <= accept;
	end

	// Destination and result only load on acceptance
	always_ff @(posedge clk) begin
		if (accept) begin
			wbRd <= iss.rd;
			wbData <= result;
		end
	end

endmodule

// ==== execCtrlRegs.sv ====
`timescale 1ns/10ps

// AXI4-Lite slave with halt, retired counter and a debug register window
module execCtrlRegs import execPkg::*; #(
	parameter int numRegs = 64
) (
	input logic clk,
	input logic rst,
	input logic [3:0] awaddr,
	input logic awvalid,
	output logic awready,
	input logic [31:0] wdata,
	input logic [3:0] wstrb,
	input logic wvalid,
	output logic wready,
	output logic [1:0] bresp,
	output logic bvalid,
	input logic bready,
	input logic [3:0] araddr,
	input logic arvalid,
	output logic arready,
	output logic [31:0] rdata,
	output logic [1:0] rresp,
	output logic rvalid,
	input logic rready,
	input logic accept0,
	input logic accept1,
	output logic issueReady,
	output RegAddr dbgRa,
	input Value dbgVal
);

	logic awFire, wFire, arFire, wrGo;
	logic awHeld, wHeld;
	logic awHeldNext, wHeldNext, bvalidNext, rvalidNext;
	logic [3:0] awAddrReg, wStrbReg, wrAddr, wrStrb;
	logic [31:0] wDataReg, wrData, readData, retired;
	logic halt;

	// Responses are always OKAY
	assign bresp = 2'b00;
	assign rresp = 2'b00;

	// Both lanes stop issuing while halted
	assign issueReady = !halt;

	// ============================================================
	// Write channels
	// ============================================================

	assign awFire = awvalid && awready;
	assign wFire = wvalid && wready;
	// Address and data may come in either order, the write goes once both are in
	assign wrGo = (awFire || awHeld) && (wFire || wHeld);
	assign wrAddr = awFire ? awaddr : awAddrReg;
	assign wrData = wFire ? wdata : wDataReg;
	assign wrStrb = wFire ? wstrb : wStrbReg;

	always_comb begin
		awHeldNext = (awHeld || awFire) && !wrGo;
		wHeldNext = (wHeld || wFire) && !wrGo;
		bvalidNext = wrGo || (bvalid && !bready);
		// A read response still waiting holds off the next read address
		rvalidNext = arFire || (rvalid && !rready);
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			awHeld <= 1'b0;
			wHeld <= 1'b0;
			bvalid <= 1'b0;
			awready <= 1'b0;
			wready <= 1'b0;
			halt <= 1'b0;
			dbgRa <= '0;
		end else begin
			awHeld <= awHeldNext;
			wHeld <= wHeldNext;
			bvalid <= bvalidNext;
			// No new address or data while one is held or the response is pending
			awready <= !awHeldNext && !bvalidNext;
			wready <= !wHeldNext && !bvalidNext;
			// The writable fields all sit in byte lane 0
			if (wrGo && wrStrb[0]) begin
				if (wrAddr == CTRL_OFFSET)
					halt <= wrData[0];
				if (wrAddr == DBGADDR_OFFSET)
					dbgRa <= RegAddr'(int'(wrData[5:0]) % numRegs);
			end
		end
	end

	// Captured address and data for the side that arrives first
	always_ff @(posedge clk) begin
		if (awFire)
			awAddrReg <= awaddr;
		if (wFire) begin
			wDataReg <= wdata;
			wStrbReg <= wstrb;
		end
	end

	// ============================================================
	// Read channel and counter
	// ============================================================

	assign arFire = arvalid && arready;

	always_comb begin
		case (araddr)
			CTRL_OFFSET: readData = {31'b0, halt};
			RETIRED_OFFSET: readData = retired;
			DBGADDR_OFFSET: readData = 32'(dbgRa);
			DBGDATA_OFFSET: readData = dbgVal[31:0];
			default: readData = '0;
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			rvalid <= 1'b0;
			arready <= 1'b0;
			retired <= '0;
		end else begin
			rvalid <= rvalidNext;
			arready <= !rvalidNext;
			// Two lanes accepting together count as two
			retired <= retired + 32'(accept0) + 32'(accept1);
		end
	end

	// Read data is held until rready
	always_ff @(posedge clk) begin
		if (arFire)
			rdata <= readData;
	end

endmodule

// ==== dualExecTop.sv ====
`timescale 1ns/10ps

// Two execute lanes around a shared register file, with a control block
module dualExecTop import execPkg::*; #(
	parameter int numRegs = 64
) (
	input logic clk,
	input logic rst,
	// Lane 0 issue slot and writeback
	input logic valid0,
	input AluOp op0,
	input RegAddr ra0,
	input RegAddr rb0,
	input RegAddr rd0,
	input logic useImm0,
	input Value imm0,
	input CodeAddress ip0,
	output logic ready0,
	output logic wbValid0,
	output RegAddr wbRd0,
	output Value wbData0,
	// Lane 1 issue slot and writeback
	input logic valid1,
	input AluOp op1,
	input RegAddr ra1,
	input RegAddr rb1,
	input RegAddr rd1,
	input logic useImm1,
	input Value imm1,
	input CodeAddress ip1,
	output logic ready1,
	output logic wbValid1,
	output RegAddr wbRd1,
	output Value wbData1,
	// AXI4-Lite control bus
	input logic [3:0] awaddr,
	input logic awvalid,
	output logic awready,
	input logic [31:0] wdata,
	input logic [3:0] wstrb,
	input logic wvalid,
	output logic wready,
	output logic [1:0] bresp,
	output logic bvalid,
	input logic bready,
	input logic [3:0] araddr,
	input logic arvalid,
	output logic arready,
	output logic [31:0] rdata,
	output logic [1:0] rresp,
	output logic rvalid,
	input logic rready
);

	issueIf iss0 ();
	issueIf iss1 ();

	logic issueReady, accept0, accept1;
	RegAddr laneRaA0, laneRaB0, laneRaA1, laneRaB1, dbgRa;
	Value valA0, valB0, valA1, valB1, dbgVal;

	// Issue slots filled from the plain ports
	assign iss0.valid = valid0;
	assign iss0.op = op0;
	assign iss0.ra = ra0;
	assign iss0.rb = rb0;
	assign iss0.rd = rd0;
	assign iss0.useImm = useImm0;
	assign iss0.imm = imm0;
	assign iss0.ip = ip0;
	assign iss1.valid = valid1;
	assign iss1.op = op1;
	assign iss1.ra = ra1;
	assign iss1.rb = rb1;
	assign iss1.rd = rd1;
	assign iss1.useImm = useImm1;
	assign iss1.imm = imm1;
	assign iss1.ip = ip1;

	// One halt bit gates both lanes
	assign iss0.ready = issueReady;
	assign iss1.ready = issueReady;
	assign ready0 = issueReady;
	assign ready1 = issueReady;

	// Acceptance feeds the retired counter
	assign accept0 = valid0 && issueReady;
	assign accept1 = valid1 && issueReady;

	aluLane lane0 (
		.clk(clk), .rst(rst), .iss(iss0),
		.raA(laneRaA0), .raB(laneRaB0), .valA(valA0), .valB(valB0),
		.wbValid(wbValid0), .wbRd(wbRd0), .wbData(wbData0)
	);

	aluLane lane1 (
		.clk(clk), .rst(rst), .iss(iss1),
		.raA(laneRaA1), .raB(laneRaB1), .valA(valA1), .valB(valB1),
		.wbValid(wbValid1), .wbRd(wbRd1), .wbData(wbData1)
	);

	// Ports 0 and 2 carry the A sources, so they get the address substitution
	gpRegfile #(.numRegs(numRegs)) regs (
		.clk(clk), .rst(rst),
		.wr0(wbValid0), .wr1(wbValid1), .wa0(wbRd0), .wa1(wbRd1),
		.wd0(wbData0), .wd1(wbData1), .ip0(iss0.ip), .ip1(iss1.ip),
		.ra0(laneRaA0), .ra1(laneRaB0), .ra2(laneRaA1), .ra3(laneRaB1),
		.o0(valA0), .o1(valB0), .o2(valA1), .o3(valB1),
		.dbgRa(dbgRa), .dbgVal(dbgVal)
	);

	execCtrlRegs #(.numRegs(numRegs)) ctrl (
		.clk(clk), .rst(rst),
		.awaddr(awaddr), .awvalid(awvalid), .awready(awready),
		.wdata(wdata), .wstrb(wstrb), .wvalid(wvalid), .wready(wready),
		.bresp(bresp), .bvalid(bvalid), .bready(bready),
		.araddr(araddr), .arvalid(arvalid), .arready(arready),
		.rdata(rdata), .rresp(rresp), .rvalid(rvalid), .rready(rready),
		.accept0(accept0), .accept1(accept1), .issueReady(issueReady),
		.dbgRa(dbgRa), .dbgVal(dbgVal)
	);

endmodule

// ==== dualExec_assert.sv ====
`timescale 1ns/10ps

// Protocol and timing checks, bound into the top level of the execute slice
module dualExecAssert import execPkg::*; (
	input logic clk,
	input logic rst,
	input logic valid0,
	input logic ready0,
	input RegAddr rd0,
	input logic wbValid0,
	input RegAddr wbRd0,
	input logic valid1,
	input logic ready1,
	input RegAddr rd1,
	input logic wbValid1,
	input RegAddr wbRd1,
	input Value wbData1,
	input logic awvalid,
	input logic awready,
	input logic wvalid,
	input logic wready,
	input logic bvalid,
	input logic bready,
	input logic arvalid,
	input logic arready,
	input logic rvalid,
	input logic rready,
	input logic [31:0] rdata,
	input RegAddr dbgRa,
	input Value dbgVal
);

	// Number of failed assertions, read back by the testbench at the end
	int failCount = 0;

	// ============================================================
	// Lane writeback timing and halt
	// ============================================================

	// An accepted instruction writes back one cycle later with its own rd
	wb0Timing: assert property (@(posedge clk) disable iff (rst)
		valid0 && ready0 |=> wbValid0 && wbRd0 == $past(rd0))
		else begin failCount++; $error("lane 0 writeback missing or wrong rd"); end
	wb1Timing: assert property (@(posedge clk) disable iff (rst)
		valid1 && ready1 |=> wbValid1 && wbRd1 == $past(rd1))
		else begin failCount++; $error("lane 1 writeback missing or wrong rd"); end

	// Without ready nothing is taken, so nothing may write back
	haltNoWb: assert property (@(posedge clk) disable iff (rst)
		!ready0 || !ready1 |=> !wbValid0 && !wbValid1)
		else begin failCount++; $error("writeback appeared while halted"); end

	// Reset leaves no writeback and no bus response pending
	resetClear: assert property (@(posedge clk)
		rst |=> !wbValid0 && !wbValid1 && !bvalid && !rvalid)
		else begin failCount++; $error("reset did not clear valid outputs"); end

	// ============================================================
	// AXI4-Lite handshakes
	// ============================================================

	awHold: assert property (@(posedge clk) disable iff (rst)
		awvalid && !awready |=> awvalid)
		else begin failCount++; $error("awvalid dropped before awready"); end
	wHold: assert property (@(posedge clk) disable iff (rst)
		wvalid && !wready |=> wvalid)
		else begin failCount++; $error("wvalid dropped before wready"); end
	arHold: assert property (@(posedge clk) disable iff (rst)
		arvalid && !arready |=> arvalid)
		else begin failCount++; $error("arvalid dropped before arready"); end
	bHold: assert property (@(posedge clk) disable iff (rst)
		bvalid && !bready |=> bvalid)
		else begin failCount++; $error("bvalid dropped before bready"); end
	// Read data must also stay put while the response waits
	rHold: assert property (@(posedge clk) disable iff (rst)
		rvalid && !rready |=> rvalid && $stable(rdata))
		else begin failCount++; $error("read response changed before rready"); end

	// ============================================================
	// Register file write priority
	// ============================================================

	// A double write to the watched register leaves lane 1's value, unless
	// a newer write to the same register bypasses it in the next cycle
	lane1Wins: assert property (@(posedge clk) disable iff (rst)
		wbValid0 && wbValid1 && wbRd0 == wbRd1 && wbRd0 == dbgRa
		|=> !$stable(dbgRa) || (wbValid0 && wbRd0 == dbgRa)
			|| (wbValid1 && wbRd1 == dbgRa) || dbgVal == $past(wbData1))
		else begin failCount++; $error("lane 1 did not win a same-register write"); end

endmodule

bind dualExecTop dualExecAssert chk (
	.clk(clk), .rst(rst),
	.valid0(valid0), .ready0(ready0), .rd0(rd0), .wbValid0(wbValid0), .wbRd0(wbRd0),
	.valid1(valid1), .ready1(ready1), .rd1(rd1), .wbValid1(wbValid1), .wbRd1(wbRd1),
	.wbData1(wbData1),
	.awvalid(awvalid), .awready(awready), .wvalid(wvalid), .wready(wready),
	.bvalid(bvalid), .bready(bready), .arvalid(arvalid), .arready(arready),
	.rvalid(rvalid), .rready(rready), .rdata(rdata),
	.dbgRa(dbgRa), .dbgVal(dbgVal)
);

// ==== tbDualExec.sv ====
`timescale 1ns/10ps

module tbDualExec import execPkg::*; ();

	localparam int numRegs = 64;
	localparam int clkPeriod = 4;
	localparam int resetCycles = 16;
	localparam int randomCycles = 200;
	localparam int haltedCycles = 4;
	localparam int resumeCycles = 20;
	localparam int directedCycles = 8;
	// Bus transactions and the cycles each may take at most
	localparam int busTxns = 6;
	localparam int busCycles = 8;
	localparam int watchdogCycles = (resetCycles + randomCycles + haltedCycles + resumeCycles
		+ directedCycles + busTxns * busCycles) * 4;

	logic clk = 1'b0;
	logic rst;

	// Issue slots, index is the lane
	logic [1:0] valid;
	logic [1:0] ready;
	AluOp op [2];
	RegAddr ra [2];
	RegAddr rb [2];
	RegAddr rd [2];
	logic [1:0] useImm;
	Value imm [2];
	CodeAddress ip [2];
	logic [1:0] wbValid;
	RegAddr wbRd [2];
	Value wbData [2];

	// AXI4-Lite master side
	logic [3:0] awaddr, araddr;
	logic awvalid, awready, wvalid, wready, bvalid, bready;
	logic arvalid, arready, rvalid, rready;
	logic [31:0] wdata, rdata;
	logic [3:0] wstrb;
	logic [1:0] bresp, rresp;

	// Shadow copy of the register file and the expected writebacks
	Value shadow [numRegs];
	logic [1:0] expValid;
	RegAddr expRd [2];
	Value expData [2];

	// Halt bit as last written over the bus
	logic halted = 1'b0;

	CodeAddress pc = 64'h0000_0000_0001_0000;
	logic [31:0] rngState = 32'h8c4c_6645;
	int accepted = 0;
	int dataErrors = 0;
	int busErrors = 0;

	always #(clkPeriod / 2) clk = !clk;

	dualExecTop #(.numRegs(numRegs)) UUT (
		.clk(clk), .rst(rst),
		.valid0(valid[0]), .op0(op[0]), .ra0(ra[0]), .rb0(rb[0]), .rd0(rd[0]),
		.useImm0(useImm[0]), .imm0(imm[0]), .ip0(ip[0]), .ready0(ready[0]),
		.wbValid0(wbValid[0]), .wbRd0(wbRd[0]), .wbData0(wbData[0]),
		.valid1(valid[1]), .op1(op[1]), .ra1(ra[1]), .rb1(rb[1]), .rd1(rd[1]),
		.useImm1(useImm[1]), .imm1(imm[1]), .ip1(ip[1]), .ready1(ready[1]),
		.wbValid1(wbValid[1]), .wbRd1(wbRd[1]), .wbData1(wbData[1]),
		.awaddr(awaddr), .awvalid(awvalid), .awready(awready),
		.wdata(wdata), .wstrb(wstrb), .wvalid(wvalid), .wready(wready),
		.bresp(bresp), .bvalid(bvalid), .bready(bready),
		.araddr(araddr), .arvalid(arvalid), .arready(arready),
		.rdata(rdata), .rresp(rresp), .rvalid(rvalid), .rready(rready)
	);

	// ============================================================
	// Reference model
	// ============================================================

	function automatic logic [31:0] xorshift(logic [31:0] x);
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	// The eight lane operations, shifts take six bits of the amount
	function automatic Value modelAlu(AluOp f, Value a, Value b);
		case (f)
			aluAdd: return a + b;
			aluSub: return a - b;
			aluAnd: return a & b;
			aluOr: return a | b;
			aluXor: return a ^ b;
			aluSll: return a << b[5:0];
			aluSrl: return a >> b[5:0];
			aluSlt: return ($signed(a) < $signed(b)) ? 64'd1 : 64'd0;
			default: return '0;
		endcase
	endfunction

	// Register 0 is zero, register 31 on source A is the lane's ip
	function automatic Value readSource(RegAddr r, logic isA, CodeAddress ipVal);
		if (r == 6'd0)
			return '0;
		if (isA && r == ipRegNum)
			return ipVal;
		return shadow[r];
	endfunction

	// ============================================================
	// Clocking and lane stimulus
	// ============================================================

	task automatic waitEdge();
		@(posedge clk);
		#0.5;
	endtask

	// Moves one cycle and compares the writebacks that are due now
	task automatic stepClock();
		waitEdge();
		for (int i = 0; i < 2; i++) begin
			if (wbValid[i] !== expValid[i]) begin
				$display("mismatch at %0t: wbValid%0d got %b expected %b",
					$time, i, wbValid[i], expValid[i]);
				dataErrors++;
			end else if (expValid[i]) begin
				if (wbRd[i] !== expRd[i]) begin
					$display("mismatch at %0t: wbRd%0d got %0d expected %0d",
						$time, i, wbRd[i], expRd[i]);
					dataErrors++;
				end
				if (wbData[i] !== expData[i]) begin
					$display("mismatch at %0t: wbData%0d got %h expected %h",
						$time, i, wbData[i], expData[i]);
					dataErrors++;
				end
			end
			expValid[i] = 1'b0;
		end
	endtask

	// Both lanes are ready unless halted
	task automatic checkReady();
		logic [1:0] expReady;
		expReady = halted ? 2'b00 : 2'b11;
		if (ready !== expReady) begin
			$display("mismatch at %0t: ready got %b expected %b", $time, ready, expReady);
			busErrors++;
		end
	endtask

	task automatic setLane(input int i, input AluOp opSel, input RegAddr srcA,
			input RegAddr srcB, input RegAddr dest, input logic immSel, input Value immVal);
		valid[i] = 1'b1;
		op[i] = opSel;
		ra[i] = srcA;
		rb[i] = srcB;
		rd[i] = dest;
		useImm[i] = immSel;
		imm[i] = immVal;
		ip[i] = pc + 64'(i) * 64'd4;
	endtask

	task automatic randomLane(input int i);
		logic [31:0] r, hi, lo;
		RegAddr srcA;
		rngState = xorshift(rngState);
		r = rngState;
		rngState = xorshift(rngState);
		hi = rngState;
		rngState = xorshift(rngState);
		lo = rngState;
		// A small register range keeps dependencies frequent
		srcA = (r[7:5] == 3'd7) ? ipRegNum : RegAddr'(r[10:8]);
		setLane(i, AluOp'(r[4:2]), srcA, RegAddr'(r[13:11]), RegAddr'(r[16:14]), r[17],
			{hi, lo});
		// One slot in four stays empty
		if (r[1:0] == 2'b00)
			valid[i] = 1'b0;
	endtask

	// Both lanes read the same state, lane 1 is applied last since it wins a tie
	task automatic issueInstr();
		Value a, b;
		logic [1:0] take;
		checkReady();
		take = halted ? 2'b00 : valid;
		for (int i = 0; i < 2; i++) begin
			expValid[i] = take[i];
			if (take[i]) begin
				a = readSource(ra[i], 1'b1, ip[i]);
				b = useImm[i] ? imm[i] : readSource(rb[i], 1'b0, ip[i]);
				expRd[i] = rd[i];
				expData[i] = modelAlu(op[i], a, b);
			end
		end
		for (int i = 0; i < 2; i++)
			if (take[i])
				shadow[expRd[i]] = expData[i];
		accepted += int'(take[0]) + int'(take[1]);
		pc = pc + 64'd8;
		stepClock();
		valid = 2'b00;
	endtask

	// ============================================================
	// AXI4-Lite master
	// ============================================================

	// Order 0 sends both channels together, 1 the data first, 2 the address first
	task automatic writeCsr(input logic [3:0] addr, input logic [31:0] data, input int order);
		logic awHit, wHit, awDone, wDone;
		awDone = 1'b0;
		wDone = 1'b0;
		awaddr = addr;
		wdata = data;
		wstrb = 4'hF;
		awvalid = (order != 1);
		wvalid = (order != 2);
		while (!(awDone && wDone)) begin
			// Ready does not change between here and the next edge
			awHit = awvalid && awready;
			wHit = wvalid && wready;
			waitEdge();
			if (awHit) begin
				awDone = 1'b1;
				awvalid = 1'b0;
			end
			if (wHit) begin
				wDone = 1'b1;
				wvalid = 1'b0;
			end
			if (awDone && !wDone)
				wvalid = 1'b1;
			if (wDone && !awDone)
				awvalid = 1'b1;
		end
		while (!bvalid)
			waitEdge();
		// The response waits one cycle before it is taken
		waitEdge();
		bready = 1'b1;
		compareBus("bresp", 32'(bresp), 32'd0);
		waitEdge();
		bready = 1'b0;
	endtask

	task automatic readCsr(input logic [3:0] addr, output logic [31:0] data);
		araddr = addr;
		arvalid = 1'b1;
		while (!arready)
			waitEdge();
		waitEdge();
		arvalid = 1'b0;
		while (!rvalid)
			waitEdge();
		waitEdge();
		rready = 1'b1;
		data = rdata;
		compareBus("rresp", 32'(rresp), 32'd0);
		waitEdge();
		rready = 1'b0;
	endtask

	task automatic compareBus(input string name, input logic [31:0] got,
			input logic [31:0] expected);
		if (got !== expected) begin
			$display("mismatch at %0t: %s got %h expected %h", $time, name, got, expected);
			busErrors++;
		end
	endtask

	// ============================================================
	// Test sequence
	// ============================================================

	initial begin
		logic [31:0] busData;
		logic [31:0] ctrlData;
		int totalErrors;
		rst = 1'b1;
		valid = 2'b00;
		useImm = 2'b00;
		expValid = 2'b00;
		for (int i = 0; i < 2; i++) begin
			op[i] = aluAdd;
			ra[i] = '0;
			rb[i] = '0;
			rd[i] = '0;
			imm[i] = '0;
			ip[i] = '0;
		end
		for (int i = 0; i < numRegs; i++)
			shadow[i] = '0;
		awaddr = '0;
		awvalid = 1'b0;
		wdata = '0;
		wstrb = '0;
		wvalid = 1'b0;
		bready = 1'b0;
		araddr = '0;
		arvalid = 1'b0;
		rready = 1'b0;
		repeat (resetCycles) @(posedge clk);
		#0.5;
		rst = 1'b0;

		// Requests go out while the slave ready outputs are still low
		fork
			writeCsr(DBGADDR_OFFSET, 32'd9, 0);
			readCsr(CTRL_OFFSET, ctrlData);
		join
		compareBus("rdata (CTRL)", ctrlData, 32'd0);

		// Register 0 reads zero, then r1 is needed at once through the bypass
		setLane(0, aluAdd, 6'd0, 6'd0, 6'd1, 1'b1, 64'h1234);
		issueInstr();
		setLane(0, aluAdd, 6'd1, 6'd1, 6'd2, 1'b0, '0);
		setLane(1, aluAdd, ipRegNum, 6'd0, 6'd3, 1'b1, 64'd8);
		issueInstr();
		setLane(0, aluXor, ipRegNum, 6'd2, 6'd5, 1'b0, '0);
		setLane(1, aluSlt, 6'd3, 6'd2, 6'd6, 1'b0, '0);
		issueInstr();

		// Both lanes hit the watched register, lane 1 must win
		setLane(0, aluOr, 6'd0, 6'd0, 6'd9, 1'b1, 64'h1111_1111_aaaa_aaaa);
		setLane(1, aluOr, 6'd0, 6'd0, 6'd9, 1'b1, 64'h2222_2222_5555_5555);
		issueInstr();
		stepClock();
		readCsr(DBGDATA_OFFSET, busData);
		compareBus("rdata (DBGDATA)", busData, shadow[9][31:0]);

		repeat (randomCycles) begin
			randomLane(0);
			randomLane(1);
			issueInstr();
		end

		// Halted lanes refuse everything that is offered
		writeCsr(CTRL_OFFSET, 32'd1, 1);
		halted = 1'b1;
		checkReady();
		repeat (haltedCycles) begin
			randomLane(0);
			randomLane(1);
			issueInstr();
		end
		writeCsr(CTRL_OFFSET, 32'd0, 2);
		halted = 1'b0;
		repeat (resumeCycles) begin
			randomLane(0);
			randomLane(1);
			issueInstr();
		end

		readCsr(RETIRED_OFFSET, busData);
		compareBus("rdata (RETIRED)", busData, 32'(accepted));

		totalErrors = dataErrors + busErrors + UUT.chk.failCount;
		$display("Errors: %0d writeback, %0d bus, %0d assertion (%0d instructions retired)",
			dataErrors, busErrors, UUT.chk.failCount, accepted);
		if (totalErrors == 0)
			$display("Test passed");
		else
			$display("Test failed");
		$finish;
	end

	// Ends a hung run, sized from the issue cycles and bus transactions
	initial begin
		#(watchdogCycles * clkPeriod);
		$display("Watchdog expired at %0t before the tests finished", $time);
		$display("Test failed");
		$finish;
	end

endmodule

// ==== compile.f ====
execPkg.sv
issueIf.sv
gpRegfile.sv
aluLane.sv
execCtrlRegs.sv
dualExecTop.sv
dualExec_assert.sv
tbDualExec.sv

// ==== Makefile ====
TOOL     = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = tbDualExec
FILELIST = compile.f

.PHONY: sim clean

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	@out=$$(./obj_dir/V$(TOP)); echo "$$out"; echo "$$out" | grep -qx "Test passed"

clean:
	rm -rf obj_dir
